/* dv/tb_rv_core.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module tb_rv_core;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_PROGRAMS = 5;
	localparam int PROG_LEN = 40;
	localparam int DATA_BASE_WORD = 128;
	localparam int DATA_WORDS = 8;
	localparam int POST_HALT = 12;
	localparam int AW = $clog2(`RV_MEM_WORDS);
	localparam logic [31:0] DATA_BASE = 32'(DATA_BASE_WORD * 4);
	localparam logic [31:0] LFSR_SEED = 32'd72866;
	localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;
	// a load is the longest instruction with two bus transfers
	localparam int INSTR_CYCLES = 8 + 2 * `RV_BUS_WAIT;
	localparam int LOAD_WORDS = PROG_LEN + 1 + DATA_WORDS;
	localparam int WATCHDOG_NS = NUM_PROGRAMS * (PROG_LEN + 1) * INSTR_CYCLES * CLK_PERIOD
		+ NUM_PROGRAMS * (RESET_CYCLES + LOAD_WORDS + POST_HALT + 4) * CLK_PERIOD;

	// instruction kinds of the generator
	// a jump group is LUI then ADDI then JALR
	localparam int K_ALUI = 0, K_ALUR = 1, K_LUI = 2, K_AUIPC = 3, K_LOAD = 4;
	localparam int K_STORE = 5, K_BRANCH = 6, K_JAL = 7, K_JGRP = 8, K_JADD = 9;
	localparam int K_JREG = 10, K_HALT = 11;

	logic clk, rts, load_en;
	logic [31:0] load_addr, load_data;
	logic retire, wb_en, halted;
	logic [31:0] retire_pc, wb_data;
	logic [4:0] wb_addr;

	logic [31:0] lfsr;
	int kind [0:PROG_LEN];
	logic [31:0] image [0:`RV_MEM_WORDS-1];
	logic [31:0] m_mem [0:`RV_MEM_WORDS-1];
	logic [31:0] m_regs [0:31];
	logic [31:0] m_pc, exp_pc, exp_wd;
	logic [4:0] exp_wa;
	logic exp_we, m_halted, running;
	int m_count, prog_retired, total_retired, errors;

	rv_core_top DUT (
		.clk, .rts, .load_en, .load_addr, .load_data,
		.retire, .retire_pc, .wb_en, .wb_addr, .wb_data, .halted
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'b0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
		end
		return v;
	endfunction

	// forward target that never lands inside a jump group
	function automatic int fwd_target(input int from);
		int t;
		t = from + 1 + int'(rand_bits(3));
		if (t > PROG_LEN)
			t = PROG_LEN;
		while (kind[t] == K_JADD || kind[t] == K_JREG)
			t++;
		return t;
	endfunction

	function automatic logic [31:0] data_addr(input logic [1:0] size);
		logic [31:0] off;
		off = rand_bits(5);
		if (size == 2'd1)
			off[0] = 1'b0;
		if (size == 2'd2)
			off[1:0] = 2'b00;
		return DATA_BASE + off;
	endfunction

	task automatic build_program();
		int i, k, t, jt, sel;
		logic [4:0] rd, rs1, rs2;
		logic [2:0] f3;
		logic [11:0] imm;
		logic [31:0] off, addr;
		logic alt;
		i = 0;
		jt = PROG_LEN;
		while (i < PROG_LEN) begin
			k = int'(rand_bits(4) % 9);
			if (k == K_JGRP && i > PROG_LEN - 3)
				k = K_ALUI;
			kind[i] = k;
			if (k == K_JGRP) begin
				kind[i + 1] = K_JADD;
				kind[i + 2] = K_JREG;
				i += 3;
			end else
				i++;
		end
		kind[PROG_LEN] = K_HALT;
		for (i = 0; i < PROG_LEN; i++) begin
			rd = 5'(rand_bits(5));
			// x31 only ever holds a jump target
			if (rd == 5'd31)
				rd = 5'd0;
			rs1 = 5'(rand_bits(5));
			rs2 = 5'(rand_bits(5));
			f3 = 3'(rand_bits(3));
			alt = rand_bits(1) != 32'b0;
			case (kind[i])
				K_ALUI: begin
					imm = 12'(rand_bits(12));
					if (f3 == 3'd1)
						imm = {7'b0, imm[4:0]};
					if (f3 == 3'd5)
						imm = {1'b0, alt, 5'b0, imm[4:0]};
					image[i] = {imm, rs1, f3, rd, 7'h13};
				end
				K_ALUR: image[i] = {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0,
					rs2, rs1, f3, rd, 7'h33};
				K_LUI: image[i] = {20'(rand_bits(20)), rd, 7'h37};
				K_AUIPC: image[i] = {20'(rand_bits(20)), rd, 7'h17};
				K_LOAD: begin
					sel = int'(rand_bits(3) % 5);
					f3 = 3'(sel < 3 ? sel : sel + 1);
					addr = data_addr(f3[1:0]);
					image[i] = {addr[11:0], 5'd0, f3, rd, 7'h03};
				end
				K_STORE: begin
					f3 = 3'(rand_bits(2) % 3);
					addr = data_addr(f3[1:0]);
					image[i] = {addr[11:5], rs2, 5'd0, f3, addr[4:0], 7'h23};
				end
				K_BRANCH: begin
					sel = int'(rand_bits(3) % 6);
					f3 = 3'(sel < 2 ? sel : sel + 2);
					t = fwd_target(i);
					off = 32'((t - i) * 4);
					image[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
				end
				K_JAL: begin
					t = fwd_target(i);
					off = 32'((t - i) * 4);
					image[i] = {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
				end
				K_JGRP: begin
					jt = fwd_target(i + 2);
					image[i] = {20'b0, 5'd31, 7'h37};
				end
				K_JADD: image[i] = {12'(jt * 4), 5'd31, 3'b000, 5'd31, 7'h13};
				K_JREG: image[i] = {12'b0, 5'd31, 3'b000, rd, 7'h67};
				default: image[i] = 32'b0;
			endcase
		end
		image[PROG_LEN] = 32'b0;
		for (int n = 0; n < DATA_WORDS; n++)
			image[DATA_BASE_WORD + n] = rand_bits(32);
	endtask

	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// executes the instruction at m_pc and leaves the expected retire in exp_*
	task automatic model_step();
		logic [31:0] ins, a, b, imm_i, imm_s, imm_b, imm_j, addr, w, nxt;
		logic [2:0] f3;
		logic take;
		ins = m_mem[m_pc[AW+1:2]];
		f3 = ins[14:12];
		a = m_regs[ins[19:15]];
		b = m_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		exp_pc = m_pc;
		exp_wa = ins[11:7];
		exp_we = 1'b1;
		exp_wd = m_pc + 32'd4;
		nxt = m_pc + 32'd4;
		case (ins[6:0])
			7'h37: exp_wd = {ins[31:12], 12'b0};
			7'h17: exp_wd = m_pc + {ins[31:12], 12'b0};
			7'h6f: nxt = m_pc + imm_j;
			7'h67: nxt = (a + imm_i) & ~32'd1;
			7'h13: exp_wd = alu_model(f3, f3 == 3'd5 && ins[30], a, imm_i);
			7'h33: exp_wd = alu_model(f3, ins[30], a, b);
			7'h63: begin
				exp_we = 1'b0;
				case (f3)
					3'd0: take = a == b;
					3'd1: take = a != b;
					3'd4: take = $signed(a) < $signed(b);
					3'd5: take = $signed(a) >= $signed(b);
					3'd6: take = a < b;
					default: take = a >= b;
				endcase
				if (take)
					nxt = m_pc + imm_b;
			end
			7'h03: begin
				addr = a + imm_i;
				w = m_mem[addr[AW+1:2]] >> (8 * addr[1:0]);
				case (f3)
					3'd0: exp_wd = {{24{w[7]}}, w[7:0]};
					3'd1: exp_wd = {{16{w[15]}}, w[15:0]};
					3'd4: exp_wd = {24'b0, w[7:0]};
					3'd5: exp_wd = {16'b0, w[15:0]};
					default: exp_wd = w;
				endcase
			end
			7'h23: begin
				exp_we = 1'b0;
				addr = a + imm_s;
				for (int k = 0; k < (1 << f3[1:0]); k++)
					m_mem[addr[AW+1:2]][8 * (int'(addr[1:0]) + k) +: 8] = b[8 * k +: 8];
			end
			default: report_failure("model met an opcode the generator never emits");
		endcase
		if (exp_wa == 5'd0)
			exp_we = 1'b0;
		if (exp_we)
			m_regs[exp_wa] = exp_wd;
		m_pc = nxt;
		m_count++;
		m_halted = (m_mem[m_pc[AW+1:2]] == 32'b0);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expv,
		input logic [31:0] actv);
		errors++;
		$display("Error at %0t ns: %s expected %h actual %h", $time, name, expv, actv);
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("Failure at %0t ns: %s", $time, msg);
	endtask

	// check each retire pulse against the model
	always @(negedge clk) begin
		if (running && !rts) begin
			if (retire) begin
				prog_retired++;
				if (m_halted)
					report_failure("retire pulse after the program reached its zero word");
				else begin
					model_step();
					if (retire_pc !== exp_pc)
						report_mismatch("retire_pc", exp_pc, retire_pc);
					if (wb_en !== exp_we)
						report_mismatch("wb_en", 32'(exp_we), 32'(wb_en));
					if (exp_we && wb_en && wb_addr !== exp_wa)
						report_mismatch("wb_addr", 32'(exp_wa), 32'(wb_addr));
					if (exp_we && wb_en && wb_data !== exp_wd)
						report_mismatch("wb_data", exp_wd, wb_data);
				end
			end else if (wb_en)
				report_failure("register write seen without a retire pulse");
		end
	end

	task automatic reset_and_load();
		int w;
		@(posedge clk);
		#2;
		rts = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		// reset stays high while the image goes in through the load port
		for (int n = 0; n < LOAD_WORDS; n++) begin
			w = (n <= PROG_LEN) ? n : DATA_BASE_WORD + n - PROG_LEN - 1;
			#2;
			load_en = 1'b1;
			load_addr = 32'(w * 4);
			load_data = image[w];
			@(posedge clk);
		end
		#2;
		load_en = 1'b0;
		m_mem = image;
		for (int r = 0; r < 32; r++)
			m_regs[r] = 32'b0;
		m_pc = `RV_RESET_PC;
		m_halted = (m_mem[m_pc[AW+1:2]] == 32'b0);
		m_count = 0;
		prog_retired = 0;
		running = 1'b1;
		@(posedge clk);
		#2;
		rts = 1'b0;
	endtask

	task automatic run_program();
		while (halted !== 1'b1)
			@(negedge clk);
		repeat (POST_HALT) @(negedge clk);
		running = 1'b0;
		if (!m_halted)
			report_failure("core halted before the model reached the zero word");
		while (!m_halted && m_count <= PROG_LEN)
			model_step();
		if (prog_retired != m_count)
			report_mismatch("retire count", 32'(m_count), 32'(prog_retired));
		total_retired += prog_retired;
	endtask

	initial begin
		rts = 1'b1;
		load_en = 1'b0;
		load_addr = 32'b0;
		load_data = 32'b0;
		running = 1'b0;
		m_halted = 1'b0;
		errors = 0;
		total_retired = 0;
		prog_retired = 0;
		lfsr = LFSR_SEED;
		for (int p = 0; p < NUM_PROGRAMS; p++) begin
			build_program();
			reset_and_load();
			run_program();
		end
		$display("programs %0d, instructions retired %0d, errors %0d",
			NUM_PROGRAMS, total_retired, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all programs halted, errors %0d", errors);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* include/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// number of 32-bit words in the program/data memory
`define RV_MEM_WORDS 1024

// extra access cycles the memory adds before it raises pready
`define RV_BUS_WAIT 1

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* logic/apb_ram.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module apb_ram (
	input  logic        clk,
	input  logic        rts,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] paddr,
	input  logic [31:0] pwdata,
	input  logic [3:0]  pstrb,
	output logic [31:0] prdata,
	output logic        pready,
	input  logic        load_en,
	input  logic [31:0] load_addr,
	input  logic [31:0] load_data
);

	localparam int AW = $clog2(`RV_MEM_WORDS);
	localparam logic [7:0] WAIT = 8'(`RV_BUS_WAIT);

	logic [31:0] mem [0:`RV_MEM_WORDS-1];
	logic [7:0] wait_cnt;
	logic [AW-1:0] widx;

	assign widx = paddr[AW+1:2];

	// wait counter restarts on every setup cycle
	always_ff @(posedge clk or posedge rts) begin
		if (rts)
			wait_cnt <= 8'd0;
		else if (psel && !penable)
			wait_cnt <= 8'd0;
		else if (psel && penable && !pready)
			wait_cnt <= wait_cnt + 8'd1;
	end

	assign pready = psel && penable && (wait_cnt == WAIT);
	assign prdata = mem[widx];

	always_ff @(posedge clk) begin
		if (rts) begin
			if (load_en)
				mem[load_addr[AW+1:2]] <= load_data;
		end else if (psel && penable && pready && pwrite) begin
			for (int i = 0; i < 4; i++)
				if (pstrb[i])
					mem[widx][8*i +: 8] <= pwdata[8*i +: 8];
		end
	end

	a_enable_follows_select: assert property (@(posedge clk) disable iff (rts)
		penable |-> $past(psel));

endmodule

/* logic/rv_alu.sv */
`timescale 1ns/1ns

module rv_alu import rv_pkg::*; (
	input  alu_op_e     op,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic [31:0] result,
	output logic        eq,
	output logic        lt,
	output logic        ltu
);

	logic [4:0] shamt;

	// shifts only look at the low five bits
	assign shamt = b[4:0];

	// compare flags for branch resolution
	assign eq  = (a == b);
	assign lt  = ($signed(a) < $signed(b));
	assign ltu = (a < b);

	always_comb begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLL:  result = a << shamt;
			ALU_SLT:  result = {31'b0, lt};
			ALU_SLTU: result = {31'b0, ltu};
			ALU_XOR:  result = a ^ b;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			default:  result = 32'b0;
		endcase
	end

endmodule

/* logic/rv_core_top.sv */
`timescale 1ns/1ns

module rv_core_top import rv_pkg::*; (
	input  logic        clk,
	input  logic        rts,
	input  logic        load_en,
	input  logic [31:0] load_addr,
	input  logic [31:0] load_data,
	output logic        retire,
	output logic [31:0] retire_pc,
	output logic        wb_en,
	output logic [4:0]  wb_addr,
	output logic [31:0] wb_data,
	output logic        halted
);

	alu_op_e alu_op;
	logic [31:0] alu_a, alu_b, alu_result;
	logic alu_eq, alu_lt, alu_ltu;
	logic [4:0] ra0, ra1;
	logic [31:0] rd0, rd1;
	logic psel, penable, pwrite, pready;
	logic [31:0] paddr, pwdata, prdata;
	logic [3:0] pstrb;

	rv_sequencer u_seq (
		.clk, .rts,
		.alu_op, .alu_a, .alu_b, .alu_result, .alu_eq, .alu_lt, .alu_ltu,
		.ra0, .ra1, .rd0, .rd1,
		.wr_en(wb_en), .wr_addr(wb_addr), .wr_data(wb_data),
		.psel, .penable, .pwrite, .paddr, .pwdata, .pstrb, .prdata, .pready,
		.retire, .retire_pc, .halted
	);

	rv_alu u_alu (
		.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result),
		.eq(alu_eq), .lt(alu_lt), .ltu(alu_ltu)
	);

	// write port also feeds the status outputs
	rv_regfile u_regs (
		.clk, .rts, .ra0, .ra1, .rd0, .rd1,
		.wr_en(wb_en), .wr_addr(wb_addr), .wr_data(wb_data)
	);

	apb_ram u_ram (
		.clk, .rts, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb, .prdata, .pready,
		.load_en, .load_addr, .load_data
	);

endmodule

/* logic/rv_pkg.sv */
package rv_pkg;

	// RV32I major opcodes handled by the core
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	// instruction phases of the sequencer
	typedef enum logic [2:0] {
		FETCH_SETUP,
		FETCH_ACCESS,
		EXECUTE,
		MEM_SETUP,
		MEM_ACCESS,
		WRITEBACK,
		HALTED
	} seq_state_e;

endpackage

/* logic/rv_regfile.sv */
`timescale 1ns/1ns

module rv_regfile (
	input  logic        clk,
	input  logic        rts,
	input  logic [4:0]  ra0,
	input  logic [4:0]  ra1,
	output logic [31:0] rd0,
	output logic [31:0] rd1,
	input  logic        wr_en,
	input  logic [4:0]  wr_addr,
	input  logic [31:0] wr_data
);

	// x0 has no storage
	logic [31:0] regs [1:31];

	always_ff @(posedge clk or posedge rts) begin
		if (rts) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= 32'b0;
		end else if (wr_en && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rd0 = (ra0 == 5'd0) ? 32'b0 : regs[ra0];
	assign rd1 = (ra1 == 5'd0) ? 32'b0 : regs[ra1];

	// a write with a floating index would corrupt a random register
	a_wr_addr_known: assert property (@(posedge clk) disable iff (rts)
		wr_en |-> !$isunknown(wr_addr));

endmodule

/* logic/rv_sequencer.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_sequencer import rv_pkg::*; (
	input  logic        clk,
	input  logic        rts,
	output alu_op_e     alu_op,
	output logic [31:0] alu_a,
	output logic [31:0] alu_b,
	input  logic [31:0] alu_result,
	input  logic        alu_eq,
	input  logic        alu_lt,
	input  logic        alu_ltu,
	output logic [4:0]  ra0,
	output logic [4:0]  ra1,
	input  logic [31:0] rd0,
	input  logic [31:0] rd1,
	output logic        wr_en,
	output logic [4:0]  wr_addr,
	output logic [31:0] wr_data,
	output logic        psel,
	output logic        penable,
	output logic        pwrite,
	output logic [31:0] paddr,
	output logic [31:0] pwdata,
	output logic [3:0]  pstrb,
	input  logic [31:0] prdata,
	input  logic        pready,
	output logic        retire,
	output logic [31:0] retire_pc,
	output logic        halted
);

	seq_state_e state;
	logic [31:0] pc, npc, ir, maddr, wb_val;
	opcode_e opcode;
	logic [2:0] funct3;
	logic [4:0] rd_idx;
	logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [31:0] pc_plus4, next_pc, exec_val, load_shift, load_val;
	logic [1:0] byte_off;
	logic [3:0] store_strb;
	logic is_branch, is_store, is_load, has_rd, taken, mem_phase;

	assign opcode = opcode_e'(ir[6:0]);
	assign funct3 = ir[14:12];
	assign rd_idx = ir[11:7];
	assign ra0 = ir[19:15];
	assign ra1 = ir[24:20];

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u = {ir[31:12], 12'b0};
	assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

	assign is_branch = (opcode == OPC_BRANCH);
	assign is_store  = (opcode == OPC_STORE);
	assign is_load   = (opcode == OPC_LOAD);
	assign has_rd    = (opcode inside {OPC_LUI, OPC_AUIPC,
		OPC_JAL, OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP});
	assign pc_plus4  = pc + 32'd4;

	// operand and operation select
	always_comb begin
		alu_op = ALU_ADD;
		alu_a  = rd0;
		alu_b  = imm_i;
		if (opcode == OPC_OP || opcode == OPC_BRANCH)
			alu_b = rd1;
		else if (opcode == OPC_STORE)
			alu_b = imm_s;
		else if (opcode == OPC_AUIPC) begin
			alu_a = pc;
			alu_b = imm_u;
		end
		if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
			case (funct3)
				3'b000: alu_op = (opcode == OPC_OP && ir[30]) ? ALU_SUB : ALU_ADD;
				3'b001: alu_op = ALU_SLL;
				3'b010: alu_op = ALU_SLT;
				3'b011: alu_op = ALU_SLTU;
				3'b100: alu_op = ALU_XOR;
				3'b101: alu_op = ir[30] ? ALU_SRA : ALU_SRL;
				3'b110: alu_op = ALU_OR;
				default: alu_op = ALU_AND;
			endcase
		end
	end

	always_comb begin
		case (funct3)
			3'b000:  taken = alu_eq;
			3'b001:  taken = !alu_eq;
			3'b100:  taken = alu_lt;
			3'b101:  taken = !alu_lt;
			3'b110:  taken = alu_ltu;
			3'b111:  taken = !alu_ltu;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		next_pc  = pc_plus4;
		exec_val = alu_result;
		case (opcode)
			OPC_BRANCH: next_pc = taken ? pc + imm_b : pc_plus4;
			OPC_JAL: begin
				next_pc  = pc + imm_j;
				exec_val = pc_plus4;
			end
			OPC_JALR: begin
				next_pc  = {alu_result[31:1], 1'b0};
				exec_val = pc_plus4;
			end
			OPC_LUI: exec_val = imm_u;
			default: ;
		endcase
	end

	// load lane extraction and store lane placement
	assign byte_off   = maddr[1:0];
	assign load_shift = prdata >> {byte_off, 3'b000};
	always_comb begin
		case (funct3)
			3'b000:  load_val = {{24{load_shift[7]}}, load_shift[7:0]};
			3'b001:  load_val = {{16{load_shift[15]}}, load_shift[15:0]};
			3'b100:  load_val = {24'b0, load_shift[7:0]};
			3'b101:  load_val = {16'b0, load_shift[15:0]};
			default: load_val = load_shift;
		endcase
		case (funct3[1:0])
			2'b00:   store_strb = 4'b0001 << byte_off;
			2'b01:   store_strb = 4'b0011 << byte_off;
			default: store_strb = 4'b1111;
		endcase
	end

	always_ff @(posedge clk or posedge rts) begin
		if (rts) begin
			state <= FETCH_SETUP;
			pc    <= `RV_RESET_PC;
			ir    <= 32'b0;
		end else begin
			case (state)
				FETCH_SETUP: state <= FETCH_ACCESS;
				FETCH_ACCESS: if (pready) begin
					ir    <= prdata;
					state <= (prdata == 32'b0) ? HALTED : EXECUTE;
				end
				EXECUTE: begin
					if (is_branch) begin
						pc    <= next_pc;
						state <= FETCH_SETUP;
					end else if (is_load || is_store)
						state <= MEM_SETUP;
					else
						state <= WRITEBACK;
				end
				MEM_SETUP: state <= MEM_ACCESS;
				MEM_ACCESS: if (pready) begin
					if (is_store) begin
						pc    <= npc;
						state <= FETCH_SETUP;
					end else
						state <= WRITEBACK;
				end
				WRITEBACK: begin
					pc    <= npc;
					state <= FETCH_SETUP;
				end
				HALTED: ;
				default: state <= FETCH_SETUP;
			endcase
		end
	end

	// results of EXECUTE kept for the memory and write-back phases
	always_ff @(posedge clk or posedge rts) begin
		if (rts) begin
			npc    <= `RV_RESET_PC;
			wb_val <= 32'b0;
			maddr  <= 32'b0;
		end else if (state == EXECUTE) begin
			npc    <= next_pc;
			wb_val <= exec_val;
			maddr  <= alu_result;
		end else if (state == MEM_ACCESS && pready && is_load)
			wb_val <= load_val;
	end

	assign mem_phase = (state == MEM_SETUP) || (state == MEM_ACCESS);
	assign psel    = (state == FETCH_SETUP) || (state == FETCH_ACCESS) || mem_phase;
	assign penable = (state == FETCH_ACCESS) || (state == MEM_ACCESS);
	assign pwrite  = mem_phase && is_store;
	assign paddr   = mem_phase ? {maddr[31:2], 2'b00} : pc;
	assign pwdata  = rd1 << {byte_off, 3'b000};
	assign pstrb   = pwrite ? store_strb : 4'b0000;

	assign wr_en   = (state == WRITEBACK) && has_rd && (rd_idx != 5'd0);
	assign wr_addr = rd_idx;
	assign wr_data = wb_val;

	assign retire    = (state == WRITEBACK) || (state == EXECUTE && is_branch)
		|| (state == MEM_ACCESS && pready && is_store);
	assign retire_pc = pc;
	assign halted    = (state == HALTED);

	a_penable_after_psel: assert property (@(posedge clk) disable iff (rts)
		$rose(penable) |-> $past(psel));
	// the slave may sample the request on any waited cycle
	a_req_stable: assert property (@(posedge clk) disable iff (rts)
		penable && !pready |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata));
	a_no_retire_halted: assert property (@(posedge clk) disable iff (rts)
		halted |=> halted && !retire);

endmodule

/* project.f */
+incdir+include
logic/rv_pkg.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_sequencer.sv
logic/apb_ram.sv
logic/rv_core_top.sv
dv/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then judge the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns -f project.f \
	--top-module tb_rv_core -o tb_rv_core > build.log 2>&1 \
	&& ./obj_dir/tb_rv_core > sim.log 2>&1 \
	|| { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
